/* common/image_geom_pkg.sv */
package image_geom_pkg;

    // frame geometry
    localparam int IMAGE_WIDTH  = 8;
    localparam int IMAGE_HEIGHT = 6;
    localparam int CHANNELS     = 4;

    // pooling window, non-overlapping
    localparam int WINDOW_SIZE       = 2;
    localparam int WINDOWS_PER_ROW   = IMAGE_WIDTH / WINDOW_SIZE;
    localparam int WINDOWS_PER_FRAME = WINDOWS_PER_ROW * (IMAGE_HEIGHT / WINDOW_SIZE);

    localparam int ROW_BITS    = $clog2(IMAGE_HEIGHT);
    localparam int COL_BITS    = $clog2(IMAGE_WIDTH);
    localparam int WINDOW_BITS = $clog2(WINDOWS_PER_FRAME);

    // coordinates inside one frame
    typedef logic [ROW_BITS-1:0] row_t;
    typedef logic [COL_BITS-1:0] col_t;

    // running window number within a scan
    typedef logic [WINDOW_BITS-1:0] window_index_t;

endpackage

/* common/pixel_pkg.sv */
package pixel_pkg;

    localparam int DATA_BITS = 32;

    // one sample of one channel
    typedef logic [DATA_BITS-1:0] data_word_t;

    // one raster pixel, word per channel
    typedef data_word_t [image_geom_pkg::CHANNELS-1:0] pixel_vec_t;

    // 2x2 block of one channel, indexed [row][col]
    typedef data_word_t [image_geom_pkg::WINDOW_SIZE-1:0][image_geom_pkg::WINDOW_SIZE-1:0]
        window_t;

    // same window position across all channels
    typedef window_t [image_geom_pkg::CHANNELS-1:0] window_vec_t;

endpackage

/* common/store_if.sv */
`timescale 1ns/1ps

interface store_if;

    // raster write port
    logic                   wr_en;
    image_geom_pkg::row_t   wr_row;
    image_geom_pkg::col_t   wr_col;
    pixel_pkg::pixel_vec_t  wr_pixel;

    // window read port, corner is top-left
    image_geom_pkg::row_t   rd_row;
    image_geom_pkg::col_t   rd_col;
    pixel_pkg::window_vec_t rd_window;

    modport fill (
        output wr_en, wr_row, wr_col, wr_pixel
    );

    modport scan (
        output rd_row, rd_col,
        input  rd_window
    );

    modport store (
        input  wr_en, wr_row, wr_col, wr_pixel,
        input  rd_row, rd_col,
        output rd_window
    );

endinterface

/* frame_store/frame_store.sv */
`timescale 1ns/1ps

module frame_store (
    input logic     clk,
    store_if.store  bus
);

    pixel_pkg::window_vec_t window_w;

    for (genvar c = 0; c < image_geom_pkg::CHANNELS; c++) begin : g_chan

        // whole frame of one channel
        pixel_pkg::data_word_t mem [image_geom_pkg::IMAGE_HEIGHT][image_geom_pkg::IMAGE_WIDTH];

        always_ff @(posedge clk) begin
            if (bus.wr_en) begin
                mem[bus.wr_row][bus.wr_col] <= bus.wr_pixel[c];
            end
        end

        // 2x2 read around the corner, combinational
        for (genvar r = 0; r < image_geom_pkg::WINDOW_SIZE; r++) begin : g_row
            for (genvar q = 0; q < image_geom_pkg::WINDOW_SIZE; q++) begin : g_col
                assign window_w[c][r][q] =
                    mem[bus.rd_row + image_geom_pkg::row_t'(r)]
                       [bus.rd_col + image_geom_pkg::col_t'(q)];
            end
        end

    end

    assign bus.rd_window = window_w;

    // fill counters must never leave the frame
    wr_addr_in_frame: assert property (
        @(posedge clk)
        bus.wr_en |-> (bus.wr_row < image_geom_pkg::IMAGE_HEIGHT) &&
                      (bus.wr_col < image_geom_pkg::IMAGE_WIDTH)
    ) else $error("frame_store write outside frame at row %0d col %0d",
                  bus.wr_row, bus.wr_col);

endmodule

/* frame_store/raster_fill.sv */
`timescale 1ns/1ps

module raster_fill (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  pixel_valid,
    input  pixel_pkg::pixel_vec_t pixel_in,
    input  logic                  scan_last,
    output logic                  scan_start,
    output logic                  reading,
    store_if.fill                 bus
);

    localparam image_geom_pkg::row_t LAST_ROW =
        image_geom_pkg::row_t'(image_geom_pkg::IMAGE_HEIGHT - 1);
    localparam image_geom_pkg::col_t LAST_COL =
        image_geom_pkg::col_t'(image_geom_pkg::IMAGE_WIDTH - 1);

    image_geom_pkg::row_t row;
    image_geom_pkg::col_t col;
    logic                 accept;
    logic                 last_pixel;

    // pixels offered during the scan are dropped
    assign accept     = pixel_valid && !reading;
    assign last_pixel = accept && (row == LAST_ROW) && (col == LAST_COL);

    assign bus.wr_en    = accept;
    assign bus.wr_row   = row;
    assign bus.wr_col   = col;
    assign bus.wr_pixel = pixel_in;

    // raster position
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            row <= '0;
            col <= '0;
        end else if (accept) begin
            if (col == LAST_COL) begin
                col <= '0;
                if (row == LAST_ROW) begin
                    row <= '0;
                end else begin
                    row <= row + 1'b1;
                end
            end else begin
                col <= col + 1'b1;
            end
        end
    end

    // fill / scan phase
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            reading    <= 1'b0;
            scan_start <= 1'b0;
        end else begin
            scan_start <= last_pixel;
            if (last_pixel) begin
                reading <= 1'b1;
            end else if (scan_last) begin
                reading <= 1'b0;
            end
        end
    end

    // scanner may only finish a scan this block started
    scan_last_in_phase: assert property (
        @(posedge clk) disable iff (!rst_n)
        scan_last |-> reading
    ) else $error("scan_last outside the reading phase");

endmodule

/* window_scan/window_scan.sv */
`timescale 1ns/1ps

module window_scan (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          scan_start,
    output logic                          scan_last,
    store_if.scan                         bus,
    output logic                          window_valid,
    output pixel_pkg::window_vec_t        window_out,
    output image_geom_pkg::window_index_t window_index,
    output logic                          frame_done
);

    localparam image_geom_pkg::row_t LAST_CORNER_ROW =
        image_geom_pkg::row_t'(image_geom_pkg::IMAGE_HEIGHT - image_geom_pkg::WINDOW_SIZE);
    localparam image_geom_pkg::col_t LAST_CORNER_COL =
        image_geom_pkg::col_t'(image_geom_pkg::IMAGE_WIDTH - image_geom_pkg::WINDOW_SIZE);
    localparam image_geom_pkg::row_t ROW_STEP =
        image_geom_pkg::row_t'(image_geom_pkg::WINDOW_SIZE);
    localparam image_geom_pkg::col_t COL_STEP =
        image_geom_pkg::col_t'(image_geom_pkg::WINDOW_SIZE);

    image_geom_pkg::row_t          corner_row;
    image_geom_pkg::col_t          corner_col;
    image_geom_pkg::window_index_t scan_idx;
    logic                          active;
    logic                          issue;

    // first address goes out in the start cycle itself
    assign issue     = scan_start || active;
    assign scan_last = issue && (corner_row == LAST_CORNER_ROW) &&
                       (corner_col == LAST_CORNER_COL);

    assign bus.rd_row = corner_row;
    assign bus.rd_col = corner_col;

    // corner walk, stride 2, wraps to 0 after the last window
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active     <= 1'b0;
            corner_row <= '0;
            corner_col <= '0;
            scan_idx   <= '0;
        end else begin
            if (scan_start) begin
                active <= 1'b1;
            end else if (scan_last) begin
                active <= 1'b0;
            end
            if (issue) begin
                scan_idx <= scan_last ? '0 : scan_idx + 1'b1;
                if (corner_col == LAST_CORNER_COL) begin
                    corner_col <= '0;
                    corner_row <= (corner_row == LAST_CORNER_ROW) ? '0 : corner_row + ROW_STEP;
                end else begin
                    corner_col <= corner_col + COL_STEP;
                end
            end
        end
    end

    // output strobe, index and sticky done
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            window_valid <= 1'b0;
            window_index <= '0;
            frame_done   <= 1'b0;
        end else begin
            window_valid <= issue;
            if (issue) begin
                window_index <= scan_idx;
            end
            if (scan_last) begin
                frame_done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            window_out <= bus.rd_window;
        end
    end

    // a new frame may only be handed over once the previous scan ended
    no_start_while_scanning: assert property (
        @(posedge clk) disable iff (!rst_n)
        scan_start |-> !active
    ) else $error("scan_start while a scan is running");

    index_in_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        window_valid |-> (window_index < image_geom_pkg::WINDOWS_PER_FRAME)
    ) else $error("window_index %0d past the last window", window_index);

endmodule

/* source/pool_window_buffer.sv */
`timescale 1ns/1ps

module pool_window_buffer (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          pixel_valid,
    input  pixel_pkg::pixel_vec_t         pixel_in,
    output logic                          window_valid,
    output pixel_pkg::window_vec_t        window_out,
    output image_geom_pkg::window_index_t window_index,
    output logic                          reading,
    output logic                          frame_done
);

    logic scan_start;
    logic scan_last;

    store_if store_bus ();

    // frame memory, written in raster order, read as 2x2 blocks
    frame_store frame_store_i (
        .clk (clk),
        .bus (store_bus.store)
    );

    raster_fill raster_fill_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .pixel_valid (pixel_valid),
        .pixel_in    (pixel_in),
        .scan_last   (scan_last),
        .scan_start  (scan_start),
        .reading     (reading),
        .bus         (store_bus.fill)
    );

    window_scan window_scan_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .scan_start   (scan_start),
        .scan_last    (scan_last),
        .bus          (store_bus.scan),
        .window_valid (window_valid),
        .window_out   (window_out),
        .window_index (window_index),
        .frame_done   (frame_done)
    );

endmodule

/* bench/pool_window_buffer_tb.sv */
`timescale 1ns/1ps

module pool_window_buffer_tb;

    localparam int CLK_PERIOD         = 8;
    localparam int RESET_CYCLES       = 2;
    localparam int FRAMES             = 3;
    localparam int PIXELS             = image_geom_pkg::IMAGE_WIDTH * image_geom_pkg::IMAGE_HEIGHT;
    localparam int WINDOWS            = image_geom_pkg::WINDOWS_PER_FRAME;
    localparam int LAST_WINDOW        = WINDOWS - 1;
    localparam int FIRST_WINDOW_DELAY = 2;
    localparam int TAIL_CYCLES        = 4;
    localparam int TIMEOUT_CYCLES     = RESET_CYCLES + FRAMES * (2 * PIXELS + WINDOWS + 4);
    localparam logic [15:0] LFSR_SEED = 16'd30942;
    localparam logic [15:0] LFSR_TAPS = 16'hB400;

    logic                          clk;
    logic                          rst_n;
    logic                          pixel_valid;
    pixel_pkg::pixel_vec_t         pixel_in;
    logic                          window_valid;
    pixel_pkg::window_vec_t        window_out;
    image_geom_pkg::window_index_t window_index;
    logic                          reading;
    logic                          frame_done;

    logic [15:0]           lfsr_state;
    // frame as the DUT should have stored it, accepted pixels only
    pixel_pkg::pixel_vec_t model_frame [image_geom_pkg::IMAGE_HEIGHT][image_geom_pkg::IMAGE_WIDTH];
    int                    model_row;
    int                    model_col;
    logic                  scan_pending;
    int                    pending_cycles;
    int                    next_index;
    int                    scans_done;
    logic                  done_expected;

    pool_window_buffer pool_window_buffer_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .pixel_valid  (pixel_valid),
        .pixel_in     (pixel_in),
        .window_valid (window_valid),
        .window_out   (window_out),
        .window_index (window_index),
        .reading      (reading),
        .frame_done   (frame_done)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        logic [15:0] shifted;
        shifted = state >> 1;
        if (state[0]) begin
            shifted = shifted ^ LFSR_TAPS;
        end
        return shifted;
    endfunction

    // one lfsr step per bit taken
    function automatic logic [31:0] random_bits(input int count);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < count; i++) begin
            bits = {bits[30:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
        return bits;
    endfunction

    // window n covers rows 2*(n div 4).. and columns 2*(n mod 4)..
    function automatic pixel_pkg::window_vec_t expected_window(input int n);
        pixel_pkg::window_vec_t win;
        int base_row;
        int base_col;
        base_row = image_geom_pkg::WINDOW_SIZE * (n / image_geom_pkg::WINDOWS_PER_ROW);
        base_col = image_geom_pkg::WINDOW_SIZE * (n % image_geom_pkg::WINDOWS_PER_ROW);
        for (int c = 0; c < image_geom_pkg::CHANNELS; c++) begin
            for (int r = 0; r < image_geom_pkg::WINDOW_SIZE; r++) begin
                for (int q = 0; q < image_geom_pkg::WINDOW_SIZE; q++) begin
                    win[c][r][q] = model_frame[base_row + r][base_col + q][c];
                end
            end
        end
        return win;
    endfunction

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Done: errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic compare(input string name, input logic [127:0] got, input logic [127:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("Error: %s got 0x%0h expected 0x%0h", name, got, exp));
        end
    endtask

    task automatic drive_pixel();
        pixel_pkg::pixel_vec_t words;
        for (int c = 0; c < image_geom_pkg::CHANNELS; c++) begin
            words[c] = random_bits(32);
        end
        // keep offering during the scan, those pixels must be dropped
        if (reading) begin
            pixel_valid <= 1'b1;
        end else begin
            pixel_valid <= (random_bits(2) != 0);
        end
        pixel_in <= words;
    endtask

    task automatic check_cycle();
        pixel_pkg::window_vec_t exp_win;
        logic                   exp_reading;
        if (scan_pending) begin
            pending_cycles++;
        end
        if (window_valid) begin
            exp_reading = (next_index != LAST_WINDOW);
        end else begin
            exp_reading = scan_pending;
        end
        compare("reading", reading, exp_reading);
        if (window_valid) begin
            if (next_index == 0) begin
                if (!scan_pending) begin
                    fail_run("a window appeared without a complete frame");
                end
                if (pending_cycles != FIRST_WINDOW_DELAY) begin
                    fail_run("window 0 appeared at the wrong cycle after the last pixel");
                end
                scan_pending = 1'b0;
            end
            compare("window_index", window_index, next_index);
            exp_win = expected_window(next_index);
            for (int c = 0; c < image_geom_pkg::CHANNELS; c++) begin
                compare($sformatf("window_out[%0d]", c), window_out[c], exp_win[c]);
            end
            if (next_index == LAST_WINDOW) begin
                done_expected = 1'b1;
                next_index    = 0;
                scans_done++;
            end else begin
                next_index++;
            end
        end else if (next_index != 0) begin
            fail_run("window_valid dropped in the middle of a scan");
        end else if (scan_pending && pending_cycles >= FIRST_WINDOW_DELAY) begin
            fail_run("window 0 did not appear after the last pixel of the frame");
        end
        compare("frame_done", frame_done, done_expected);

        // record the pixel the next edge accepts
        if (pixel_valid && !reading) begin
            model_frame[model_row][model_col] = pixel_in;
            if (model_col == image_geom_pkg::IMAGE_WIDTH - 1) begin
                model_col = 0;
                if (model_row == image_geom_pkg::IMAGE_HEIGHT - 1) begin
                    model_row      = 0;
                    scan_pending   = 1'b1;
                    pending_cycles = 0;
                end else begin
                    model_row++;
                end
            end else begin
                model_col++;
            end
        end
    endtask

    initial begin : drive_proc
        lfsr_state  = LFSR_SEED;
        rst_n       = 1'b0;
        pixel_valid = 1'b0;
        pixel_in    = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        forever begin
            @(posedge clk);
            drive_pixel();
        end
    end

    initial begin : compare_proc
        int tail;
        model_row      = 0;
        model_col      = 0;
        scan_pending   = 1'b0;
        pending_cycles = 0;
        next_index     = 0;
        scans_done     = 0;
        done_expected  = 1'b0;
        tail           = 0;
        @(posedge rst_n);
        @(negedge clk);
        compare("reading", reading, 1'b0);
        compare("window_valid", window_valid, 1'b0);
        compare("frame_done", frame_done, 1'b0);
        // done level must hold a few cycles past the last scan
        while (tail < TAIL_CYCLES) begin
            check_cycle();
            if (scans_done >= FRAMES) begin
                tail++;
            end
            @(negedge clk);
        end
        $display("Done: no errors");
        $finish;
    end

    initial begin : timeout_proc
        int cycles;
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        fail_run($sformatf("timeout after %0d cycles with %0d of %0d scans seen",
                           cycles, scans_done, FRAMES));
    end

endmodule

/* pool_window_buffer.f */
common/image_geom_pkg.sv
common/pixel_pkg.sv
common/store_if.sv
frame_store/frame_store.sv
frame_store/raster_fill.sv
window_scan/window_scan.sv
source/pool_window_buffer.sv
bench/pool_window_buffer_tb.sv
